/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= axi_soc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+include
verilog/axi_soc_pkg.sv
verilog/axi_ready_lfsr.sv
verilog/axi_sram_slave.sv
verilog/axi_uart_slave.sv
verilog/axi_addr_decoder.sv
verilog/axi_soc_top.sv
verification/axi_soc_tb.sv

/* include/axi_soc_macros.svh */
`ifndef AXI_SOC_MACROS_SVH
`define AXI_SOC_MACROS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4

// address map
`define SRAM_BASE 32'h8000_0000
`define SRAM_DEPTH_WORDS 256
`define UART_ADDR 32'hA000_03F8

// slave acceptance throttling
// set to 0 for a slave that never stalls
`define READY_STALL_EN 1
`define READY_LFSR_SEED 20'h00065

`endif

/* verification/axi_soc_stimulus.txt */
# op addr data strb resp rdata, all hex except op (R read, W write)
# resp 0 is OKAY and 3 is DECERR, rdata is ignored on writes
W 80000000 deadbeef f 0 00000000
R 80000000 00000000 0 0 deadbeef
W 80000004 11223344 f 0 00000000
W 80000004 000000aa 1 0 00000000
R 80000004 00000000 0 0 112233aa
W 80000004 55660000 c 0 00000000
R 80000004 00000000 0 0 556633aa
W 800003fc cafef00d f 0 00000000
R 800003fc 00000000 0 0 cafef00d
R 80000000 00000000 0 0 deadbeef
W a00003f8 00000048 1 0 00000000
W a00003f8 00000069 f 0 00000000
W a00003f8 00000021 e 0 00000000
R a00003f8 00000000 0 0 00000002
W a00003f8 0000000a 1 0 00000000
R a00003f8 00000000 0 0 00000003
R 00001000 00000000 0 3 00000000
W 00001000 12345678 f 3 00000000
R 80000400 00000000 0 3 00000000
W a00003fc 00000041 1 3 00000000
R a00003f8 00000000 0 0 00000003
R 80000004 00000000 0 0 556633aa

/* verification/axi_soc_tb.sv */
`timescale 1ns/100ps
`include "axi_soc_macros.svh"

module axi_soc_tb;

  // one line of the stimulus file
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic [31:0] rdata;
  } stim_t;

  logic                 clk;
  logic                 arst_n;
  axi_soc_pkg::axi_ax_t m_ar;
  logic                 m_ar_valid;
  logic                 m_ar_ready;
  axi_soc_pkg::axi_r_t  m_r;
  logic                 m_r_valid;
  logic                 m_r_ready;
  axi_soc_pkg::axi_ax_t m_aw;
  logic                 m_aw_valid;
  logic                 m_aw_ready;
  axi_soc_pkg::axi_w_t  m_w;
  logic                 m_w_valid;
  logic                 m_w_ready;
  axi_soc_pkg::axi_b_t  m_b;
  logic                 m_b_valid;
  logic                 m_b_ready;
  logic                 tx_valid;
  logic [7:0]           tx_data;

  stim_t      stim_q[$];
  logic [7:0] tx_bytes[$];
  integer     seed;
  int         error_cnt;
  int         check_cnt;
  int         cycle_cnt;
  int         cycle_limit;

  axi_soc_top axi_soc_top_inst (
    .clk(clk), .arst_n_i(arst_n),
    .m_ar_i(m_ar), .m_ar_valid_i(m_ar_valid), .m_ar_ready_o(m_ar_ready),
    .m_r_o(m_r), .m_r_valid_o(m_r_valid), .m_r_ready_i(m_r_ready),
    .m_aw_i(m_aw), .m_aw_valid_i(m_aw_valid), .m_aw_ready_o(m_aw_ready),
    .m_w_i(m_w), .m_w_valid_i(m_w_valid), .m_w_ready_o(m_w_ready),
    .m_b_o(m_b), .m_b_valid_o(m_b_valid), .m_b_ready_i(m_b_ready),
    .tx_valid_o(tx_valid), .tx_data_o(tx_data)
  );

  always #4 clk = ~clk;

  // console bytes as they leave the uart
  always @(posedge clk) begin
    if (arst_n && tx_valid) begin
      tx_bytes.push_back(tx_data);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run stopped, transactions still busy after %0d clock cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_cnt++;
    if (actual !== expected) begin
      $display("ERROR @ %0t: %s got %h expected %h", $time, what, actual, expected);
      error_cnt++;
    end
  endtask

  // response ready comes up after 0 to 3 idle cycles
  task automatic ready_delay();
    int wait_cycles;
    wait_cycles = $unsigned($random(seed)) % 4;
    repeat (wait_cycles) @(posedge clk);
    if (wait_cycles != 0) #1;
  endtask

  // entered and left 1 ns after a rising edge
  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    m_ar.addr  = addr;
    m_ar_valid = 1'b1;
    @(posedge clk);
    while (!m_ar_ready) @(posedge clk);
    #1;
    m_ar_valid = 1'b0;
    ready_delay();
    m_r_ready = 1'b1;
    @(posedge clk);
    while (!m_r_valid) @(posedge clk);
    data = m_r.data;
    resp = m_r.resp;
    #1;
    m_r_ready = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    m_aw.addr  = addr;
    m_w.data   = data;
    m_w.strb   = strb;
    m_aw_valid = 1'b1;
    m_w_valid  = 1'b1;
    @(posedge clk);
    while (!(m_aw_ready && m_w_ready)) @(posedge clk);
    #1;
    m_aw_valid = 1'b0;
    m_w_valid  = 1'b0;
    ready_delay();
    m_b_ready = 1'b1;
    @(posedge clk);
    while (!m_b_valid) @(posedge clk);
    resp = m_b.resp;
    #1;
    m_b_ready = 1'b0;
  endtask

  initial begin
    stim_t       s;
    logic [31:0] rdata;
    logic [1:0]  resp;
    logic [7:0]  op_c;
    logic [31:0] addr_v;
    logic [31:0] data_v;
    logic [3:0]  strb_v;
    logic [1:0]  resp_v;
    logic [31:0] rdata_v;
    int          fd;
    int          fields;
    int          line_no;
    int          exp_tx_cnt;
    string       line;
    clk         = 1'b0;
    arst_n      = 1'b0;
    m_ar        = '0;
    m_ar_valid  = 1'b0;
    m_r_ready   = 1'b0;
    m_aw        = '0;
    m_aw_valid  = 1'b0;
    m_w         = '0;
    m_w_valid   = 1'b0;
    m_b_ready   = 1'b0;
    seed        = 32'h5c0e874a;
    error_cnt   = 0;
    check_cnt   = 0;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    exp_tx_cnt  = 0;
    line_no     = 0;

    fd = $fopen("verification/axi_soc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file verification/axi_soc_stimulus.txt");
      error_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        line_no++;
        if (line.len() < 2 || line[0] == "#") continue;
        fields = $sscanf(line, "%c %h %h %h %h %h", op_c, addr_v, data_v, strb_v,
                         resp_v, rdata_v);
        if (fields != 6) begin
          $display("stimulus line %0d has %0d fields instead of 6", line_no, fields);
          error_cnt++;
        end else begin
          s.op    = op_c;
          s.addr  = addr_v;
          s.data  = data_v;
          s.strb  = strb_v;
          s.resp  = resp_v;
          s.rdata = rdata_v;
          stim_q.push_back(s);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 200 * stim_q.size() + 100;

    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value(32'({m_ar_ready, m_aw_ready, m_w_ready, m_r_valid, m_b_valid, tx_valid}),
                32'd0, "outputs after reset");

    foreach (stim_q[i]) begin
      s = stim_q[i];
      if (s.op == "W") begin
        bus_write(s.addr, s.data, s.strb, resp);
        check_value(32'(resp), 32'(s.resp), $sformatf("entry %0d write resp", i));
        // only lane 0 carries a console byte
        if (s.addr == `UART_ADDR && s.strb[0]) begin
          exp_tx_cnt++;
          if (tx_bytes.size() != 0) begin
            check_value(32'(tx_bytes[$]), 32'(s.data[7:0]), $sformatf("entry %0d tx byte", i));
          end
        end
        check_value(32'(tx_bytes.size()), 32'(exp_tx_cnt), $sformatf("entry %0d tx count", i));
      end else if (s.op == "R") begin
        bus_read(s.addr, rdata, resp);
        check_value(32'(resp), 32'(s.resp), $sformatf("entry %0d read resp", i));
        check_value(rdata, s.rdata, $sformatf("entry %0d read data", i));
        if (s.addr == `UART_ADDR) begin
          check_value(rdata, 32'(exp_tx_cnt), $sformatf("entry %0d sent count", i));
        end
      end else begin
        $display("stimulus entry %0d has an unknown operation '%c'", i, s.op);
        error_cnt++;
      end
    end

    repeat (2) @(posedge clk);
    $display("transactions %0d, checks %0d, errors %0d", stim_q.size(), check_cnt, error_cnt);
    if (error_cnt == 0 && stim_q.size() != 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/axi_addr_decoder.sv */
`timescale 1ns/100ps
`include "axi_soc_macros.svh"

module axi_addr_decoder (
  input  logic                 clk,
  input  logic                 arst_n_i,
  // master side
  input  axi_soc_pkg::axi_ax_t m_ar_i,
  input  logic                 m_ar_valid_i,
  output logic                 m_ar_ready_o,
  output axi_soc_pkg::axi_r_t  m_r_o,
  output logic                 m_r_valid_o,
  input  logic                 m_r_ready_i,
  input  axi_soc_pkg::axi_ax_t m_aw_i,
  input  logic                 m_aw_valid_i,
  output logic                 m_aw_ready_o,
  input  axi_soc_pkg::axi_w_t  m_w_i,
  input  logic                 m_w_valid_i,
  output logic                 m_w_ready_o,
  output axi_soc_pkg::axi_b_t  m_b_o,
  output logic                 m_b_valid_o,
  input  logic                 m_b_ready_i,
  // sram side
  output axi_soc_pkg::axi_ax_t sram_ar_o,
  output logic                 sram_ar_valid_o,
  input  logic                 sram_ar_ready_i,
  input  axi_soc_pkg::axi_r_t  sram_r_i,
  input  logic                 sram_r_valid_i,
  output logic                 sram_r_ready_o,
  output axi_soc_pkg::axi_ax_t sram_aw_o,
  output logic                 sram_aw_valid_o,
  input  logic                 sram_aw_ready_i,
  output axi_soc_pkg::axi_w_t  sram_w_o,
  output logic                 sram_w_valid_o,
  input  logic                 sram_w_ready_i,
  input  axi_soc_pkg::axi_b_t  sram_b_i,
  input  logic                 sram_b_valid_i,
  output logic                 sram_b_ready_o,
  // uart side
  output axi_soc_pkg::axi_ax_t uart_ar_o,
  output logic                 uart_ar_valid_o,
  input  logic                 uart_ar_ready_i,
  input  axi_soc_pkg::axi_r_t  uart_r_i,
  input  logic                 uart_r_valid_i,
  output logic                 uart_r_ready_o,
  output axi_soc_pkg::axi_ax_t uart_aw_o,
  output logic                 uart_aw_valid_o,
  input  logic                 uart_aw_ready_i,
  output axi_soc_pkg::axi_w_t  uart_w_o,
  output logic                 uart_w_valid_o,
  input  logic                 uart_w_ready_i,
  input  axi_soc_pkg::axi_b_t  uart_b_i,
  input  logic                 uart_b_valid_i,
  output logic                 uart_b_ready_o
);

  localparam logic [`AXI_ADDR_W-1:0] SRAM_END = `SRAM_BASE + 4 * `SRAM_DEPTH_WORDS;

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_SRAM,
    TGT_UART
  } tgt_e;

  function automatic tgt_e decode(input logic [`AXI_ADDR_W-1:0] addr);
    tgt_e tgt;
    tgt = TGT_NONE;
    if (addr >= `SRAM_BASE && addr < SRAM_END) begin
      tgt = TGT_SRAM;
    end else if (addr == `UART_ADDR) begin
      tgt = TGT_UART;
    end
    return tgt;
  endfunction

  tgt_e ar_tgt;
  tgt_e aw_tgt;
  tgt_e rd_tgt_q;
  tgt_e wr_tgt_q;
  logic rd_busy_q;
  logic wr_busy_q;
  logic ar_fire;
  logic aw_fire;
  logic r_fire;
  logic b_fire;

  assign ar_tgt = decode(m_ar_i.addr);
  assign aw_tgt = decode(m_aw_i.addr);

  // payload fans out to both slaves, valid goes to one
  assign sram_ar_o = m_ar_i;
  assign uart_ar_o = m_ar_i;
  assign sram_aw_o = m_aw_i;
  assign uart_aw_o = m_aw_i;
  assign sram_w_o  = m_w_i;
  assign uart_w_o  = m_w_i;

  assign sram_ar_valid_o = m_ar_valid_i & ~rd_busy_q & (ar_tgt == TGT_SRAM);
  assign uart_ar_valid_o = m_ar_valid_i & ~rd_busy_q & (ar_tgt == TGT_UART);
  assign sram_aw_valid_o = m_aw_valid_i & ~wr_busy_q & (aw_tgt == TGT_SRAM);
  assign uart_aw_valid_o = m_aw_valid_i & ~wr_busy_q & (aw_tgt == TGT_UART);
  assign sram_w_valid_o  = m_w_valid_i & ~wr_busy_q & (aw_tgt == TGT_SRAM);
  assign uart_w_valid_o  = m_w_valid_i & ~wr_busy_q & (aw_tgt == TGT_UART);

  // response ready only to the slave that owns the outstanding request
  assign sram_r_ready_o = m_r_ready_i & rd_busy_q & (rd_tgt_q == TGT_SRAM);
  assign uart_r_ready_o = m_r_ready_i & rd_busy_q & (rd_tgt_q == TGT_UART);
  assign sram_b_ready_o = m_b_ready_i & wr_busy_q & (wr_tgt_q == TGT_SRAM);
  assign uart_b_ready_o = m_b_ready_i & wr_busy_q & (wr_tgt_q == TGT_UART);

  // unmapped requests are taken as soon as they show up
  always_comb begin
    case (ar_tgt)
      TGT_SRAM: m_ar_ready_o = ~rd_busy_q & sram_ar_ready_i;
      TGT_UART: m_ar_ready_o = ~rd_busy_q & uart_ar_ready_i;
      default:  m_ar_ready_o = ~rd_busy_q & m_ar_valid_i;
    endcase
    case (aw_tgt)
      TGT_SRAM: m_aw_ready_o = ~wr_busy_q & sram_aw_ready_i;
      TGT_UART: m_aw_ready_o = ~wr_busy_q & uart_aw_ready_i;
      default:  m_aw_ready_o = ~wr_busy_q & m_aw_valid_i & m_w_valid_i;
    endcase
    case (aw_tgt)
      TGT_SRAM: m_w_ready_o = ~wr_busy_q & sram_w_ready_i;
      TGT_UART: m_w_ready_o = ~wr_busy_q & uart_w_ready_i;
      default:  m_w_ready_o = ~wr_busy_q & m_aw_valid_i & m_w_valid_i;
    endcase
  end

  // responses steered back, local decerr otherwise
  always_comb begin
    m_r_o       = '{data: '0, resp: axi_soc_pkg::RESP_DECERR};
    m_r_valid_o = rd_busy_q;
    m_b_o       = '{resp: axi_soc_pkg::RESP_DECERR};
    m_b_valid_o = wr_busy_q;
    case (rd_tgt_q)
      TGT_SRAM: begin
        m_r_o       = sram_r_i;
        m_r_valid_o = rd_busy_q & sram_r_valid_i;
      end
      TGT_UART: begin
        m_r_o       = uart_r_i;
        m_r_valid_o = rd_busy_q & uart_r_valid_i;
      end
      default: ;
    endcase
    case (wr_tgt_q)
      TGT_SRAM: begin
        m_b_o       = sram_b_i;
        m_b_valid_o = wr_busy_q & sram_b_valid_i;
      end
      TGT_UART: begin
        m_b_o       = uart_b_i;
        m_b_valid_o = wr_busy_q & uart_b_valid_i;
      end
      default: ;
    endcase
  end

  assign ar_fire = m_ar_valid_i & m_ar_ready_o;
  assign aw_fire = m_aw_valid_i & m_aw_ready_o;
  assign r_fire  = m_r_valid_o & m_r_ready_i;
  assign b_fire  = m_b_valid_o & m_b_ready_i;

  // one outstanding transaction per direction
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_busy_q <= 1'b0;
      wr_busy_q <= 1'b0;
      rd_tgt_q  <= TGT_NONE;
      wr_tgt_q  <= TGT_NONE;
    end else begin
      if (ar_fire) begin
        rd_busy_q <= 1'b1;
        rd_tgt_q  <= ar_tgt;
      end else if (r_fire) begin
        rd_busy_q <= 1'b0;
      end
      if (aw_fire) begin
        wr_busy_q <= 1'b1;
        wr_tgt_q  <= aw_tgt;
      end else if (b_fire) begin
        wr_busy_q <= 1'b0;
      end
    end
  end

  onehot_valid_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(sram_ar_valid_o && uart_ar_valid_o) && !(sram_aw_valid_o && uart_aw_valid_o)
    && !(sram_w_valid_o && uart_w_valid_o));

endmodule

/* verilog/axi_ready_lfsr.sv */
`timescale 1ns/100ps
`include "axi_soc_macros.svh"

module axi_ready_lfsr (
  input  logic clk,
  input  logic arst_n_i,
  output logic permit_o
);

  logic [19:0] lfsr_q;

  // fibonacci form, taps 19 and 18
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= `READY_LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  // top bit gives a roughly even mix of stall and accept cycles
  assign permit_o = (`READY_STALL_EN != 0) ? lfsr_q[19] : 1'b1;

  // all-zero state would lock the slave out for good
  lfsr_nonzero_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    lfsr_q != '0);

endmodule

/* verilog/axi_soc_pkg.sv */
`include "axi_soc_macros.svh"

package axi_soc_pkg;

  // address channel, single beat so only the address travels
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } axi_ax_t;

  // write data channel
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axi_w_t;

  // read response channel
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axi_r_t;

  // write response channel
  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

endpackage

/* verilog/axi_soc_top.sv */
`timescale 1ns/100ps

module axi_soc_top (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  axi_soc_pkg::axi_ax_t m_ar_i,
  input  logic                 m_ar_valid_i,
  output logic                 m_ar_ready_o,
  output axi_soc_pkg::axi_r_t  m_r_o,
  output logic                 m_r_valid_o,
  input  logic                 m_r_ready_i,
  input  axi_soc_pkg::axi_ax_t m_aw_i,
  input  logic                 m_aw_valid_i,
  output logic                 m_aw_ready_o,
  input  axi_soc_pkg::axi_w_t  m_w_i,
  input  logic                 m_w_valid_i,
  output logic                 m_w_ready_o,
  output axi_soc_pkg::axi_b_t  m_b_o,
  output logic                 m_b_valid_o,
  input  logic                 m_b_ready_i,
  output logic                 tx_valid_o,
  output logic [7:0]           tx_data_o
);

  axi_soc_pkg::axi_ax_t sram_ar;
  axi_soc_pkg::axi_ax_t sram_aw;
  axi_soc_pkg::axi_ax_t uart_ar;
  axi_soc_pkg::axi_ax_t uart_aw;
  axi_soc_pkg::axi_w_t  sram_w;
  axi_soc_pkg::axi_w_t  uart_w;
  axi_soc_pkg::axi_r_t  sram_r;
  axi_soc_pkg::axi_r_t  uart_r;
  axi_soc_pkg::axi_b_t  sram_b;
  axi_soc_pkg::axi_b_t  uart_b;
  logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic sram_b_valid, sram_b_ready;
  logic uart_ar_valid, uart_ar_ready, uart_r_valid, uart_r_ready;
  logic uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic uart_b_valid, uart_b_ready;

  axi_addr_decoder decoder_inst (
    .clk(clk), .arst_n_i(arst_n_i),
    .m_ar_i(m_ar_i), .m_ar_valid_i(m_ar_valid_i), .m_ar_ready_o(m_ar_ready_o),
    .m_r_o(m_r_o), .m_r_valid_o(m_r_valid_o), .m_r_ready_i(m_r_ready_i),
    .m_aw_i(m_aw_i), .m_aw_valid_i(m_aw_valid_i), .m_aw_ready_o(m_aw_ready_o),
    .m_w_i(m_w_i), .m_w_valid_i(m_w_valid_i), .m_w_ready_o(m_w_ready_o),
    .m_b_o(m_b_o), .m_b_valid_o(m_b_valid_o), .m_b_ready_i(m_b_ready_i),
    .sram_ar_o(sram_ar), .sram_ar_valid_o(sram_ar_valid), .sram_ar_ready_i(sram_ar_ready),
    .sram_r_i(sram_r), .sram_r_valid_i(sram_r_valid), .sram_r_ready_o(sram_r_ready),
    .sram_aw_o(sram_aw), .sram_aw_valid_o(sram_aw_valid), .sram_aw_ready_i(sram_aw_ready),
    .sram_w_o(sram_w), .sram_w_valid_o(sram_w_valid), .sram_w_ready_i(sram_w_ready),
    .sram_b_i(sram_b), .sram_b_valid_i(sram_b_valid), .sram_b_ready_o(sram_b_ready),
    .uart_ar_o(uart_ar), .uart_ar_valid_o(uart_ar_valid), .uart_ar_ready_i(uart_ar_ready),
    .uart_r_i(uart_r), .uart_r_valid_i(uart_r_valid), .uart_r_ready_o(uart_r_ready),
    .uart_aw_o(uart_aw), .uart_aw_valid_o(uart_aw_valid), .uart_aw_ready_i(uart_aw_ready),
    .uart_w_o(uart_w), .uart_w_valid_o(uart_w_valid), .uart_w_ready_i(uart_w_ready),
    .uart_b_i(uart_b), .uart_b_valid_i(uart_b_valid), .uart_b_ready_o(uart_b_ready)
  );

  axi_sram_slave sram_inst (
    .clk(clk), .arst_n_i(arst_n_i),
    .ar_i(sram_ar), .ar_valid_i(sram_ar_valid), .ar_ready_o(sram_ar_ready),
    .r_o(sram_r), .r_valid_o(sram_r_valid), .r_ready_i(sram_r_ready),
    .aw_i(sram_aw), .aw_valid_i(sram_aw_valid), .aw_ready_o(sram_aw_ready),
    .w_i(sram_w), .w_valid_i(sram_w_valid), .w_ready_o(sram_w_ready),
    .b_o(sram_b), .b_valid_o(sram_b_valid), .b_ready_i(sram_b_ready)
  );

  axi_uart_slave uart_inst (
    .clk(clk), .arst_n_i(arst_n_i),
    .ar_i(uart_ar), .ar_valid_i(uart_ar_valid), .ar_ready_o(uart_ar_ready),
    .r_o(uart_r), .r_valid_o(uart_r_valid), .r_ready_i(uart_r_ready),
    .aw_i(uart_aw), .aw_valid_i(uart_aw_valid), .aw_ready_o(uart_aw_ready),
    .w_i(uart_w), .w_valid_i(uart_w_valid), .w_ready_o(uart_w_ready),
    .b_o(uart_b), .b_valid_o(uart_b_valid), .b_ready_i(uart_b_ready),
    .tx_valid_o(tx_valid_o), .tx_data_o(tx_data_o)
  );

endmodule

/* verilog/axi_sram_slave.sv */
`timescale 1ns/100ps
`include "axi_soc_macros.svh"

module axi_sram_slave (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  axi_soc_pkg::axi_ax_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output axi_soc_pkg::axi_r_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  input  axi_soc_pkg::axi_ax_t aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axi_soc_pkg::axi_w_t  w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output axi_soc_pkg::axi_b_t  b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i
);

  localparam int IDX_W = $clog2(`SRAM_DEPTH_WORDS);

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e                 rd_state_q;
  state_e                 wr_state_q;
  logic                   permit;
  logic                   wr_accept;
  logic [`AXI_ADDR_W-1:0] rd_off;
  logic [`AXI_ADDR_W-1:0] wr_off;
  logic [`AXI_DATA_W-1:0] rd_data_q;
  logic [`AXI_DATA_W-1:0] mem_q [`SRAM_DEPTH_WORDS];

  axi_ready_lfsr lfsr_inst (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .permit_o(permit)
  );

  // word index relative to the window base
  assign rd_off = ar_i.addr - `SRAM_BASE;
  assign wr_off = aw_i.addr - `SRAM_BASE;

  // accept only when idle and the lfsr lets us
  assign ar_ready_o = ar_valid_i & permit & (rd_state_q == ST_IDLE);
  assign wr_accept  = aw_valid_i & w_valid_i & permit & (wr_state_q == ST_IDLE);
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  assign r_valid_o = (rd_state_q == ST_RESP);
  assign b_valid_o = (wr_state_q == ST_RESP);
  assign r_o       = '{data: rd_data_q, resp: axi_soc_pkg::RESP_OKAY};
  assign b_o       = '{resp: axi_soc_pkg::RESP_OKAY};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= ST_IDLE;
      wr_state_q <= ST_IDLE;
    end else begin
      case (rd_state_q)
        ST_IDLE: if (ar_ready_o) rd_state_q <= ST_RESP;
        ST_RESP: if (r_ready_i) rd_state_q <= ST_IDLE;
      endcase
      case (wr_state_q)
        ST_IDLE: if (wr_accept) wr_state_q <= ST_RESP;
        ST_RESP: if (b_ready_i) wr_state_q <= ST_IDLE;
      endcase
    end
  end

  // storage and read capture
  always_ff @(posedge clk) begin
    if (ar_ready_o) begin
      rd_data_q <= mem_q[rd_off[IDX_W+1:2]];
    end
    if (wr_accept) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (w_i.strb[i]) begin
          mem_q[wr_off[IDX_W+1:2]][8*i +: 8] <= w_i.data[8*i +: 8];
        end
      end
    end
  end

  // response must wait for the master unchanged
  r_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

  b_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o);

endmodule

/* verilog/axi_uart_slave.sv */
`timescale 1ns/100ps
`include "axi_soc_macros.svh"

module axi_uart_slave (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  axi_soc_pkg::axi_ax_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output axi_soc_pkg::axi_r_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  input  axi_soc_pkg::axi_ax_t aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axi_soc_pkg::axi_w_t  w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output axi_soc_pkg::axi_b_t  b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output logic                 tx_valid_o,
  output logic [7:0]           tx_data_o
);

  typedef enum logic {
    ST_IDLE,
    ST_RESP
  } state_e;

  state_e                 rd_state_q;
  state_e                 wr_state_q;
  logic                   permit;
  logic                   wr_accept;
  logic                   tx_valid_q;
  logic [7:0]             tx_data_q;
  logic [31:0]            sent_cnt_q;
  logic [`AXI_DATA_W-1:0] rd_data_q;

  axi_ready_lfsr lfsr_inst (
    .clk     (clk),
    .arst_n_i(arst_n_i),
    .permit_o(permit)
  );

  // single register, ar_i and aw_i are already decoded upstream
  assign ar_ready_o = ar_valid_i & permit & (rd_state_q == ST_IDLE);
  assign wr_accept  = aw_valid_i & w_valid_i & permit & (wr_state_q == ST_IDLE);
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;

  assign r_valid_o  = (rd_state_q == ST_RESP);
  assign b_valid_o  = (wr_state_q == ST_RESP);
  assign r_o        = '{data: rd_data_q, resp: axi_soc_pkg::RESP_OKAY};
  assign b_o        = '{resp: axi_soc_pkg::RESP_OKAY};
  assign tx_valid_o = tx_valid_q;
  assign tx_data_o  = tx_data_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= ST_IDLE;
      wr_state_q <= ST_IDLE;
      tx_valid_q <= 1'b0;
      sent_cnt_q <= '0;
    end else begin
      case (rd_state_q)
        ST_IDLE: if (ar_ready_o) rd_state_q <= ST_RESP;
        ST_RESP: if (r_ready_i) rd_state_q <= ST_IDLE;
      endcase
      case (wr_state_q)
        ST_IDLE: if (wr_accept) wr_state_q <= ST_RESP;
        ST_RESP: if (b_ready_i) wr_state_q <= ST_IDLE;
      endcase
      // a byte goes out only when lane 0 is strobed
      tx_valid_q <= wr_accept & w_i.strb[0];
      if (wr_accept && w_i.strb[0]) begin
        sent_cnt_q <= sent_cnt_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      tx_data_q <= w_i.data[7:0];
    end
    if (ar_ready_o) begin
      rd_data_q <= `AXI_DATA_W'(sent_cnt_q);
    end
  end

  // one byte per write, and writes are at least two cycles apart
  tx_pulse_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_valid_o |=> !tx_valid_o);

endmodule
